/* Makefile */
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP ?= dcache_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Simulation finished: PASS
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, whatever the simulator exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/dcache_decode.sv */
////////////////////////////////////////
// Request stage
// Captures a request into stage one and
// generates ready
////////////////////////////////////////
`default_nettype none

module dcache_decode (
    input wire logic clk,
    input wire logic rst,

    // Load/store port
    input wire logic new_request,
    input wire logic [31:0] addr,
    input wire logic we,
    input wire logic [3:0] be,
    input wire logic [31:0] data_in,
    output logic ready,
    output logic write_outstanding,

    // Reset sweep or snoop write in progress
    input wire logic busy,

    dcache_req_if.decode req
);

    logic accept;

    assign accept = new_request & ready;
    assign req.accept = accept;

    ////////////////////////////////////////
    // Stage one control
    always_ff @(posedge clk) begin
        if (rst) begin
            req.valid <= 1'b0;
            req.first <= 1'b0;
            req.kind <= dcache_pkg::read;
        end else begin
            req.first <= accept;
            if (accept) begin
                req.valid <= 1'b1;
                req.kind <= we ? dcache_pkg::write : dcache_pkg::read;
            end else if (req.done) begin
                req.valid <= 1'b0;
            end
        end
    end

    // Stage one payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req.addr.raw <= addr;
            req.wdata <= data_in;
            req.be <= be;
        end
    end

    // A finishing request frees stage one in the same cycle
    assign ready = ~busy & (~req.valid | req.done);

    assign write_outstanding = req.valid & (req.kind == dcache_pkg::write);

    ////////////////////////////////////////
    // Assertions
    request_while_busy : assert property (
        @(posedge clk) disable iff (rst)
        new_request |-> ready
    ) else $error("new_request while ready is low");

endmodule

`default_nettype wire

/* design/dcache_execute.sv */
////////////////////////////////////////
// Tag lookup stage
// Tag bank, reset sweep, snoop invalidate,
// hit detection and way replacement
////////////////////////////////////////
`default_nettype none

module dcache_execute #(
    parameter int ways = 2
) (
    input wire logic clk,
    input wire logic rst,

    // Snoop port
    input wire logic inv,
    input wire dcache_pkg::dcache_addr_t inv_addr,

    // Fill tag write from the result stage
    input wire logic tag_write,
    input wire logic fill_valid,

    output logic busy,
    output logic hit,
    output logic [ways-1:0] hit_way,
    output logic hit_r,
    output logic [ways-1:0] fill_way,

    dcache_req_if.execute req
);

    dcache_pkg::tag_entry_t [ways-1:0] tag_mem [dcache_pkg::num_lines];

    ////////////////////////////////////////
    // Reset sweep
    logic sweeping;
    logic [dcache_pkg::line_bits-1:0] sweep_line;

    // Carry out of the line counter ends the sweep
    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping <= 1'b1;
            sweep_line <= '0;
        end else if (sweeping) begin
            {sweeping, sweep_line} <= {1'b1, sweep_line} + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Snoop invalidation
    // Port B reads in the cycle of inv, the hit way is cleared on port A next cycle
    logic snoop_valid;
    logic [dcache_pkg::line_bits-1:0] snoop_line_r;
    logic [dcache_pkg::tag_bits-1:0] snoop_tag_r;
    dcache_pkg::tag_entry_t [ways-1:0] snoop_rdata;
    logic [ways-1:0] snoop_hit;
    logic snoop_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            snoop_valid <= 1'b0;
        end else begin
            snoop_valid <= inv & ~sweeping;
        end
        snoop_line_r <= inv_addr.fields.line;
        snoop_tag_r <= inv_addr.fields.tag;
    end

    always_comb begin
        for (int i = 0; i < ways; i++) begin
            snoop_hit[i] = snoop_rdata[i].valid & (snoop_rdata[i].tag == snoop_tag_r);
        end
    end

    assign snoop_write = snoop_valid & |snoop_hit;
    assign busy = sweeping | snoop_write;

    ////////////////////////////////////////
    // Replacement cycler
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_way <= ways'(1);
        end else if (req.accept) begin
            for (int i = 0; i < ways; i++) begin
                fill_way[i] <= fill_way[(i + ways - 1) % ways];
            end
        end
    end

    ////////////////////////////////////////
    // Tag bank
    logic [ways-1:0] a_wen;
    logic [dcache_pkg::line_bits-1:0] a_line;
    dcache_pkg::tag_entry_t a_wdata;
    logic [dcache_pkg::line_bits-1:0] b_line;

    // Snoop write takes port A over a fill tag write
    assign a_wen = snoop_write ? snoop_hit : (tag_write ? fill_way : '0);
    assign a_line = snoop_write ? snoop_line_r : req.addr.fields.line;
    assign a_wdata.valid = ~snoop_write & fill_valid;
    assign a_wdata.tag = req.addr.fields.tag;

    assign b_line = sweeping ? sweep_line : inv_addr.fields.line;

    always_ff @(posedge clk) begin
        for (int i = 0; i < ways; i++) begin
            if (a_wen[i]) begin
                tag_mem[a_line][i] <= a_wdata;
            end
            if (sweeping) begin
                tag_mem[b_line][i] <= '0;
            end
        end
        if (inv) begin
            snoop_rdata <= tag_mem[b_line];
        end
    end

    ////////////////////////////////////////
    // Hit detection on the stage-one address
    dcache_pkg::tag_entry_t [ways-1:0] lookup_entry;
    logic [ways-1:0] lookup_hit;
    logic [ways-1:0] hit_way_r;

    assign lookup_entry = tag_mem[req.addr.fields.line];

    always_comb begin
        for (int i = 0; i < ways; i++) begin
            lookup_hit[i] = lookup_entry[i].valid
                          & (lookup_entry[i].tag == req.addr.fields.tag);
        end
    end

    assign hit = req.first & |lookup_hit;

    always_ff @(posedge clk) begin
        if (req.first) begin
            hit_way_r <= lookup_hit;
            hit_r <= |lookup_hit;
        end
    end

    // Live result in the first cycle, held copy for the rest of the request
    assign hit_way = req.first ? lookup_hit : hit_way_r;

    ////////////////////////////////////////
    // Assertions
    single_way_hit : assert property (
        @(posedge clk) disable iff (rst)
        req.valid |-> $onehot0(hit_way)
    ) else $error("line present in more than one way");

endmodule

`default_nettype wire

/* design/dcache_pkg.sv */
////////////////////////////////////////
// Data cache package
// Line geometry, address union, tag entry
// and request kind
////////////////////////////////////////
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////
    // Line geometry
    localparam int line_words = 8;
    localparam int word_bits = 3;
    localparam int line_bits = 6;
    localparam int num_lines = 64;
    // Everything above line index, word index and byte offset
    localparam int tag_bits = 32 - line_bits - word_bits - 2;

    // Address split for tag lookup and data bank indexing
    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic [line_bits-1:0] line;
        logic [word_bits-1:0] word;
        logic [1:0] offset;
    } addr_fields_t;

    // Same word seen as a byte address or as cache fields
    typedef union packed {
        logic [31:0] raw;
        addr_fields_t fields;
    } dcache_addr_t;

    ////////////////////////////////////////
    // Tag bank entry, one per way
    typedef struct packed {
        logic valid;
        logic [tag_bits-1:0] tag;
    } tag_entry_t;

    // Kind of request held in stage one
    typedef enum logic {
        read = 1'b0,
        write = 1'b1
    } req_kind_t;

endpackage

`default_nettype wire

/* design/dcache_req_if.sv */
////////////////////////////////////////
// Stage-one request bus shared by the
// decode, execute and result stages
////////////////////////////////////////
`default_nettype none

interface dcache_req_if #(
    parameter int ways = 2
);

    logic valid;
    dcache_pkg::req_kind_t kind;
    dcache_pkg::dcache_addr_t addr;
    logic [31:0] wdata;
    logic [3:0] be;
    // High only in the cycle after acceptance
    logic first;
    logic accept;
    logic done;

    // Way masks are one-hot, so at least one way is needed
    if (ways < 1) begin : g_ways_check
        $error("dcache_req_if needs at least one way");
    end

    modport decode (output valid, kind, addr, wdata, be, first, accept, input done);
    modport execute (input accept, addr, valid, first);
    modport result (input valid, kind, addr, wdata, be, first, accept, output done);
    modport monitor (input valid, kind, addr, wdata, be, first, accept, done);

endinterface

`default_nettype wire

/* design/dcache_result.sv */
////////////////////////////////////////
// Data and memory stage
// Data bank, fill counter, memory request
// control and load data return
////////////////////////////////////////
`default_nettype none

module dcache_result #(
    parameter int ways = 2
) (
    input wire logic clk,
    input wire logic rst,

    // From tag lookup
    input wire logic hit,
    input wire logic [ways-1:0] hit_way,
    input wire logic hit_r,
    input wire logic [ways-1:0] fill_way,

    // Fill tag write back to tag lookup
    output logic tag_write,
    output logic fill_valid,

    // Memory port
    output logic request,
    output logic [29:0] mem_addr,
    output logic rnw,
    output logic [31:0] wdata,
    output logic [3:0] wbe,
    output logic [4:0] rlen,
    input wire logic ack,
    input wire logic rvalid,
    input wire logic [31:0] rdata,

    // Load data return
    output logic data_valid,
    output logic [31:0] data_out,

    dcache_req_if.result req
);

    localparam int bank_bits = dcache_pkg::line_bits + dcache_pkg::word_bits;

    logic is_read;
    logic is_write;

    assign is_read = req.kind == dcache_pkg::read;
    assign is_write = req.kind == dcache_pkg::write;

    ////////////////////////////////////////
    // Fill burst counting
    logic [dcache_pkg::word_bits-1:0] fill_count;
    logic last_beat;
    logic correct_word;

    always_ff @(posedge clk) begin
        if (rst || req.done) begin
            fill_count <= '0;
        end else if (rvalid) begin
            fill_count <= fill_count + 1'b1;
        end
    end

    assign last_beat = rvalid
                     & (fill_count == dcache_pkg::word_bits'(dcache_pkg::line_words - 1));
    assign correct_word = rvalid & (fill_count == req.addr.fields.word);

    ////////////////////////////////////////
    // Memory request
    logic read_req_r;
    logic write_hit;

    // Miss request starts the cycle after the lookup, drops on ack
    always_ff @(posedge clk) begin
        if (rst || ack) begin
            read_req_r <= 1'b0;
        end else if (req.first && is_read && !hit) begin
            read_req_r <= 1'b1;
        end
    end

    assign request = read_req_r | (req.valid & is_write);
    assign mem_addr = req.addr.raw[31:2];
    assign rnw = is_read;
    assign wdata = req.wdata;
    assign wbe = req.be;
    assign rlen = is_read ? 5'(dcache_pkg::line_words - 1) : 5'd0;

    // Tag goes in one cycle after the read ack
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_write <= 1'b0;
            fill_valid <= 1'b0;
        end else begin
            tag_write <= ack & is_read;
            fill_valid <= is_read;
        end
    end

    // The ack may land in the lookup cycle itself
    assign write_hit = req.first ? hit : hit_r;

    always_comb begin
        if (is_write) begin
            req.done = ack;
        end else begin
            req.done = req.valid & (req.first ? hit : last_beat);
        end
    end

    ////////////////////////////////////////
    // Data bank
    logic [ways-1:0][31:0] data_mem [dcache_pkg::num_lines * dcache_pkg::line_words];
    logic [ways-1:0][31:0] bank_rdata;
    logic [ways-1:0] bank_wway;
    logic [3:0] bank_wbe;
    logic [31:0] bank_wdata;
    logic [bank_bits-1:0] bank_waddr;
    logic [31:0] hit_data;

    // Fill beats write the victim way, stores update the way that hit
    always_comb begin
        if (rvalid) begin
            bank_wway = fill_way;
            bank_wbe = 4'hf;
            bank_wdata = rdata;
            bank_waddr = {req.addr.fields.line, fill_count};
        end else begin
            bank_wway = (ack & is_write & write_hit) ? hit_way : '0;
            bank_wbe = req.be;
            bank_wdata = req.wdata;
            bank_waddr = {req.addr.fields.line, req.addr.fields.word};
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ways; i++) begin
            for (int b = 0; b < 4; b++) begin
                if (bank_wway[i] && bank_wbe[b]) begin
                    data_mem[bank_waddr][i][b*8 +: 8] <= bank_wdata[b*8 +: 8];
                end
            end
        end
    end

    assign bank_rdata = data_mem[{req.addr.fields.line, req.addr.fields.word}];

    always_comb begin
        hit_data = '0;
        for (int i = 0; i < ways; i++) begin
            if (hit_way[i]) begin
                hit_data = hit_data | bank_rdata[i];
            end
        end
    end

    ////////////////////////////////////////
    // Load return
    assign data_valid = req.valid & is_read & (req.first ? hit : correct_word);
    assign data_out = req.first ? hit_data : rdata;

    ////////////////////////////////////////
    // Assertions
    ack_without_request : assert property (
        @(posedge clk) disable iff (rst)
        ack |-> request
    ) else $error("memory ack without a request");

endmodule

`default_nettype wire

/* design/dcache_top.sv */
////////////////////////////////////////
// Data cache top level
// Connects the three stages to plain ports
////////////////////////////////////////
`default_nettype none

module dcache_top #(
    parameter int ways = 2
) (
    input wire logic clk,
    input wire logic rst,

    // Load/store port
    input wire logic new_request,
    input wire logic [31:0] addr,
    input wire logic we,
    input wire logic [3:0] be,
    input wire logic [31:0] data_in,
    output logic ready,
    output logic data_valid,
    output logic [31:0] data_out,

    // Memory port
    output logic request,
    output logic [29:0] mem_addr,
    output logic rnw,
    output logic [31:0] wdata,
    output logic [3:0] wbe,
    output logic [4:0] rlen,
    input wire logic ack,
    input wire logic rvalid,
    input wire logic [31:0] rdata,
    input wire logic inv,
    input wire logic [31:0] inv_addr,
    output logic write_outstanding
);

    logic busy;
    logic hit;
    logic hit_r;
    logic [ways-1:0] hit_way;
    logic [ways-1:0] fill_way;
    logic tag_write;
    logic fill_valid;

    dcache_req_if #(.ways(ways)) req_bus ();

    dcache_decode decode_i (
        .clk(clk),
        .rst(rst),
        .new_request(new_request),
        .addr(addr),
        .we(we),
        .be(be),
        .data_in(data_in),
        .ready(ready),
        .write_outstanding(write_outstanding),
        .busy(busy),
        .req(req_bus.decode)
    );

    dcache_execute #(.ways(ways)) execute_i (
        .clk(clk),
        .rst(rst),
        .inv(inv),
        .inv_addr(inv_addr),
        .tag_write(tag_write),
        .fill_valid(fill_valid),
        .busy(busy),
        .hit(hit),
        .hit_way(hit_way),
        .hit_r(hit_r),
        .fill_way(fill_way),
        .req(req_bus.execute)
    );

    dcache_result #(.ways(ways)) result_i (
        .clk(clk),
        .rst(rst),
        .hit(hit),
        .hit_way(hit_way),
        .hit_r(hit_r),
        .fill_way(fill_way),
        .tag_write(tag_write),
        .fill_valid(fill_valid),
        .request(request),
        .mem_addr(mem_addr),
        .rnw(rnw),
        .wdata(wdata),
        .wbe(wbe),
        .rlen(rlen),
        .ack(ack),
        .rvalid(rvalid),
        .rdata(rdata),
        .data_valid(data_valid),
        .data_out(data_out),
        .req(req_bus.result)
    );

endmodule

`default_nettype wire

/* verification/dcache_mem_model.sv */
////////////////////////////////////////
// Memory responder for the data cache
// Burst reads, acked writes and a shadow array
////////////////////////////////////////
`default_nettype none

module dcache_mem_model #(
    parameter logic [31:0] fill_key = 32'h0
) (
    input wire logic clk,
    input wire logic rst,
    // Adds ack delays and gaps between beats
    input wire logic gaps,

    input wire logic request,
    input wire logic [29:0] mem_addr,
    input wire logic rnw,
    input wire logic [31:0] wdata,
    input wire logic [3:0] wbe,
    input wire logic [4:0] rlen,
    output logic ack,
    output logic rvalid,
    output logic [31:0] rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] shadow [logic [29:0]];
    logic [7:0] cycle;
    logic [29:0] beat_addr;
    logic [5:0] beats_left;

    // Words never written hold a pattern of their own address
    function automatic logic [31:0] peek(input logic [29:0] word_addr);
        if (shadow.exists(word_addr)) begin
            return shadow[word_addr];
        end
        return {2'b00, word_addr} ^ fill_key;
    endfunction

    function automatic logic [31:0] apply_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] enables);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (enables[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    initial begin
        ack = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
    end

    ////////////////////////////////////////
    // Request acceptance and burst return
    always @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            rvalid <= 1'b0;
            rdata <= '0;
            cycle <= '0;
            beats_left <= '0;
        end else begin
            cycle <= cycle + 8'd1;
            ack <= 1'b0;
            rvalid <= 1'b0;
            if (beats_left != 6'd0) begin
                // Skip a beat now and then
                if (!(gaps && cycle[1:0] == 2'b11)) begin
                    rvalid <= 1'b1;
                    rdata <= peek(beat_addr);
                    beat_addr <= beat_addr + 30'd1;
                    beats_left <= beats_left - 6'd1;
                end
            end else if (request && !ack && !(gaps && cycle[2])) begin
                ack <= 1'b1;
                if (rnw) begin
                    // Bursts always start at word 0 of the line
                    beat_addr <= mem_addr & ~30'(dcache_pkg::line_words - 1);
                    beats_left <= 6'(rlen) + 6'd1;
                end else begin
                    shadow[mem_addr] = apply_bytes(peek(mem_addr), wdata, wbe);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
////////////////////////////////////////
// Data cache testbench
// Clock, reset, LFSR, compare tasks and
// directed tests
////////////////////////////////////////
`default_nettype none

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ways = 2;
    localparam logic [31:0] fill_key = 32'h5c3a_96e1;
    localparam logic [31:0] seed = 32'd82004;
    localparam int timeout_cycles = 300;

    logic clk;
    logic rst;
    logic new_request;
    logic [31:0] addr;
    logic we;
    logic [3:0] be;
    logic [31:0] data_in;
    logic ready;
    logic data_valid;
    logic [31:0] data_out;
    logic request;
    logic [29:0] mem_addr;
    logic rnw;
    logic [31:0] wdata;
    logic [3:0] wbe;
    logic [4:0] rlen;
    logic ack;
    logic rvalid;
    logic [31:0] rdata;
    logic inv;
    logic [31:0] inv_addr;
    logic write_outstanding;
    logic gaps;

    // Reference memory, LFSR state and memory port monitor
    logic [31:0] expect_mem [logic [29:0]];
    logic [31:0] lfsr;
    int read_acks;
    int write_acks;
    logic [29:0] last_read_addr;
    logic [4:0] last_rlen;
    logic [29:0] last_write_addr;
    logic [31:0] last_wdata;
    logic [3:0] last_wbe;

    dcache_top #(.ways(ways)) dut_i (
        .clk(clk), .rst(rst),
        .new_request(new_request), .addr(addr), .we(we), .be(be), .data_in(data_in),
        .ready(ready), .data_valid(data_valid), .data_out(data_out),
        .request(request), .mem_addr(mem_addr), .rnw(rnw), .wdata(wdata), .wbe(wbe),
        .rlen(rlen), .ack(ack), .rvalid(rvalid), .rdata(rdata),
        .inv(inv), .inv_addr(inv_addr), .write_outstanding(write_outstanding)
    );

    dcache_mem_model #(.fill_key(fill_key)) mem_i (
        .clk(clk), .rst(rst), .gaps(gaps),
        .request(request), .mem_addr(mem_addr), .rnw(rnw), .wdata(wdata), .wbe(wbe),
        .rlen(rlen), .ack(ack), .rvalid(rvalid), .rdata(rdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Transfers are counted in the cycle of their ack
    always @(negedge clk) begin
        if (rst) begin
            read_acks <= 0;
            write_acks <= 0;
        end else if (request && ack) begin
            if (rnw) begin
                read_acks <= read_acks + 1;
                last_read_addr <= mem_addr;
                last_rlen <= rlen;
            end else begin
                write_acks <= write_acks + 1;
                last_write_addr <= mem_addr;
                last_wdata <= wdata;
                last_wbe <= wbe;
            end
        end
    end

    ////////////////////////////////////////
    // Helpers
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [29:0] word_addr);
        if (expect_mem.exists(word_addr)) begin
            return expect_mem[word_addr];
        end
        return {2'b00, word_addr} ^ fill_key;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] enables);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (enables[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input dcache_pkg::dcache_addr_t expected,
                              input dcache_pkg::dcache_addr_t actual);
        if (actual.raw !== expected.raw) begin
            abort_run($sformatf("error %s expected %h actual %h", name, expected.raw,
                                actual.raw));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("error %s expected %b actual %b", name, expected, actual));
        end
    endtask

    ////////////////////////////////////////
    // Load/store and snoop drivers
    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ready !== 1'b1) begin
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_run($sformatf("%s timed out waiting for ready", name));
            end
            @(negedge clk);
        end
    endtask

    // Called while the cache is idle, returns on the acceptance edge
    task automatic send_request(input logic [31:0] a, input logic is_write,
                                input logic [3:0] b, input logic [31:0] d);
        @(posedge clk);
        new_request <= 1'b1;
        addr <= a;
        we <= is_write;
        be <= b;
        data_in <= d;
        @(posedge clk);
        new_request <= 1'b0;
    endtask

    task automatic read_word(input string name, input logic [31:0] a,
                             output logic [31:0] data, output int latency);
        wait_ready(name);
        send_request(a, 1'b0, 4'hf, 32'h0);
        @(negedge clk);
        latency = 1;
        while (data_valid !== 1'b1) begin
            if (latency > timeout_cycles) begin
                abort_run($sformatf("%s timed out waiting for load data", name));
            end
            @(negedge clk);
            latency++;
        end
        data = data_out;
    endtask

    task automatic write_word(input string name, input logic [31:0] a,
                              input logic [31:0] d, input logic [3:0] b);
        int cycles;
        wait_ready(name);
        send_request(a, 1'b1, b, d);
        cycles = 0;
        @(negedge clk);
        while (!(request === 1'b1 && ack === 1'b1)) begin
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_run($sformatf("%s timed out waiting for the write ack", name));
            end
            @(negedge clk);
        end
        check_flag({name, " write_outstanding"}, 1'b1, write_outstanding);
        expect_mem[a[31:2]] = merge_bytes(expected_word(a[31:2]), d, b);
    endtask

    task automatic snoop_line(input string name, input logic [31:0] a);
        wait_ready(name);
        @(posedge clk);
        inv <= 1'b1;
        inv_addr <= a;
        @(posedge clk);
        inv <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Directed tests
    task automatic sweep_after_reset();
        int low_cycles;
        int latency;
        logic [31:0] a;
        logic [31:0] data;
        dcache_pkg::dcache_addr_t want;
        dcache_pkg::dcache_addr_t seen;
        low_cycles = 0;
        a = 32'h0000_0344;
        @(negedge clk);
        check_flag("sweep_after_reset data_valid", 1'b0, data_valid);
        check_flag("sweep_after_reset request", 1'b0, request);
        check_flag("sweep_after_reset write_outstanding", 1'b0, write_outstanding);
        while (ready !== 1'b1) begin
            low_cycles++;
            if (low_cycles > timeout_cycles) begin
                abort_run("ready never rose after the reset sweep");
            end
            @(negedge clk);
        end
        check_flag("sweep_after_reset sweep length", 1'b1, low_cycles >= dcache_pkg::num_lines);
        read_word("sweep_after_reset", a, data, latency);
        check_flag("sweep_after_reset miss", 1'b1, latency > 1);
        check_word("sweep_after_reset data", expected_word(a[31:2]), data);
        check_word("sweep_after_reset read count", 32'd1, read_acks);
        want.raw = {a[31:2], 2'b00};
        seen.raw = {last_read_addr, 2'b00};
        check_addr("sweep_after_reset read address", want, seen);
        check_word("sweep_after_reset rlen", dcache_pkg::line_words - 1, 32'(last_rlen));
    endtask

    task automatic miss_then_hit();
        int latency;
        int acks;
        logic [31:0] data;
        read_word("miss_then_hit miss", 32'h0000_1240, data, latency);
        check_flag("miss_then_hit miss latency", 1'b1, latency > 1);
        check_word("miss_then_hit miss data", expected_word(30'h0000_0490), data);
        wait_ready("miss_then_hit");
        acks = read_acks;
        // Word 5 of the same line
        read_word("miss_then_hit hit", 32'h0000_1254, data, latency);
        check_word("miss_then_hit hit latency", 32'd1, latency);
        check_word("miss_then_hit hit data", expected_word(30'h0000_0495), data);
        wait_ready("miss_then_hit");
        check_word("miss_then_hit memory reads", acks, read_acks);
    endtask

    task automatic write_through();
        int latency;
        int acks;
        int writes;
        logic [31:0] data;
        dcache_pkg::dcache_addr_t want;
        dcache_pkg::dcache_addr_t seen;
        writes = write_acks;
        write_word("write_through", 32'h0000_1248, 32'hdead_beef, 4'b0101);
        wait_ready("write_through");
        check_word("write_through write count", writes + 1, write_acks);
        want.raw = 32'h0000_1248;
        seen.raw = {last_write_addr, 2'b00};
        check_addr("write_through address", want, seen);
        check_word("write_through wdata", 32'hdead_beef, last_wdata);
        check_word("write_through wbe", 32'h5, 32'(last_wbe));
        acks = read_acks;
        read_word("write_through read back", 32'h0000_1248, data, latency);
        check_word("write_through read latency", 32'd1, latency);
        check_word("write_through merged data", expected_word(30'h0000_0492), data);
        wait_ready("write_through");
        check_word("write_through memory reads", acks, read_acks);
    endtask

    task automatic snoop_invalidate();
        int latency;
        int acks;
        logic [31:0] data;
        snoop_line("snoop_invalidate", 32'h0000_1240);
        acks = read_acks;
        read_word("snoop_invalidate refetch", 32'h0000_1244, data, latency);
        check_flag("snoop_invalidate refetch miss", 1'b1, latency > 1);
        check_word("snoop_invalidate refetch data", expected_word(30'h0000_0491), data);
        wait_ready("snoop_invalidate");
        check_word("snoop_invalidate memory reads", acks + 1, read_acks);
        // Same set, tag not present
        snoop_line("snoop_invalidate other tag", 32'h0000_1a40);
        acks = read_acks;
        read_word("snoop_invalidate kept line", 32'h0000_1248, data, latency);
        check_word("snoop_invalidate kept latency", 32'd1, latency);
        check_word("snoop_invalidate kept data", expected_word(30'h0000_0492), data);
        wait_ready("snoop_invalidate");
        check_word("snoop_invalidate kept reads", acks, read_acks);
    endtask

    task automatic random_mix();
        int latency;
        int writes;
        int issued;
        logic [31:0] tag_sel;
        logic [31:0] line_sel;
        logic [31:0] word_sel;
        logic [31:0] kind;
        logic [31:0] enables;
        logic [31:0] value;
        logic [31:0] a;
        logic [31:0] data;
        writes = write_acks;
        issued = 0;
        @(posedge clk);
        gaps <= 1'b1;
        for (int i = 0; i < 200; i++) begin
            take_bits(2, tag_sel);
            take_bits(1, line_sel);
            take_bits(3, word_sel);
            take_bits(1, kind);
            // Four tags over two sets of a two-way cache
            a = 32'h0004_0180 + (tag_sel << 11) + (line_sel << 5) + (word_sel << 2);
            if (kind[0]) begin
                take_bits(4, enables);
                take_bits(32, value);
                write_word("random_mix write", a, value, enables[3:0]);
                issued++;
            end else begin
                read_word("random_mix read", a, data, latency);
                check_word($sformatf("random_mix read %h", a), expected_word(a[31:2]), data);
            end
        end
        wait_ready("random_mix");
        check_word("random_mix write count", writes + issued, write_acks);
    endtask

    initial begin
        lfsr = seed;
        rst = 1'b1;
        new_request = 1'b0;
        addr = '0;
        we = 1'b0;
        be = '0;
        data_in = '0;
        inv = 1'b0;
        inv_addr = '0;
        gaps = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        sweep_after_reset();
        miss_then_hit();
        write_through();
        snoop_invalidate();
        random_mix();
        wait_ready("end of run");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/dcache_pkg.sv
design/dcache_req_if.sv
design/dcache_decode.sv
design/dcache_execute.sv
design/dcache_result.sv
design/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv
